// File: run.sh
#!/bin/sh
# build the traceback testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f vit_trb_top.f --top-module vit_trb_tb -o vit_trb_sim

./obj_dir/vit_trb_sim | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
  echo "simulation ok"
  exit 0
else
  echo "simulation reported failure"
  exit 1
fi

// File: source/vit_pkg.sv
// shared trellis constants, types and helper functions for the Viterbi traceback blocks
package vit_pkg;

  //--------------------------------------------------------------------------
  // trellis and memory geometry
  //--------------------------------------------------------------------------

  // K=3 code, four states
  localparam int cSTATE_W     = 2;
  localparam int cSTATES      = 4;

  // survivor memory, 64 steps
  localparam int cRAM_ADDR_W  = 6;
  localparam int cRAM_DEPTH   = 2**cRAM_ADDR_W;

  // one reversal bank
  localparam int cLIFO_ADDR_W = 6;
  localparam int cLIFO_DEPTH  = 2**cLIFO_ADDR_W;

  localparam int cTAG_W       = 4;

  // generators 7 and 5 octal, newest bit is msb of the register
  localparam logic [2:0] cGEN0 = 3'b111;
  localparam logic [2:0] cGEN1 = 3'b101;

  //--------------------------------------------------------------------------
  // basic types
  //--------------------------------------------------------------------------

  typedef logic [cSTATE_W-1:0]     stateb_t;
  typedef logic [cSTATES-1:0]      decision_t;
  typedef logic [1:0]              boutputs_t;
  typedef logic [cRAM_ADDR_W-1:0]  trb_ram_addr_t;
  typedef logic [cLIFO_ADDR_W-1:0] trb_lifo_addr_t;
  typedef logic [cTAG_W-1:0]       tag_t;

  // one survivor word, written by the ACS side
  typedef struct packed {
    decision_t decision;
    boutputs_t hd;
  } trb_word_t;

  // traceback command, same layout for start and flush
  typedef struct packed {
    trb_ram_addr_t raddr;
    trb_ram_addr_t size_m1;
    trb_ram_addr_t skip;
    stateb_t       state;
    tag_t          tag;
  } trb_cmd_t;

  // one traceback result toward the reversal buffer
  typedef struct packed {
    logic           dat;
    boutputs_t      biterr;
    trb_lifo_addr_t waddr;
    tag_t           tag;
  } trb_bit_t;

  //--------------------------------------------------------------------------
  // trellis rule
  //--------------------------------------------------------------------------

  // predecessor: low state bit moves up, decision fills the low bit
  function automatic stateb_t get_pre_state(stateb_t s, logic d);
    return {s[0], d};
  endfunction

  // info bit that led into a state
  function automatic logic get_binput(stateb_t s);
    return s[1];
  endfunction

  // code pair for a transition out of state s with input bit b
  function automatic boutputs_t get_outputs(stateb_t s, logic b);
    logic [2:0] sr;
    sr = {b, s};
    return {^(sr & cGEN0), ^(sr & cGEN1)};
  endfunction

endpackage

// File: source/vit_trb_engine.sv
// traceback engine, walks survivor memory backwards and feeds bits to the reversal buffer
`timescale 1ns/1ps

module vit_trb_engine (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  // full traceback request
  input  logic                   istart,
  input  vit_pkg::trb_cmd_t      icmd,
  // buffer tail flush request
  input  logic                   iflush,
  input  vit_pkg::trb_cmd_t      ifcmd,
  output logic                   ordy,
  // survivor memory
  output vit_pkg::trb_ram_addr_t oraddr,
  input  vit_pkg::trb_word_t     irword,
  // reversal buffer
  output logic                   owrite,
  output logic                   oflush,
  output vit_pkg::trb_bit_t      obit
);

  import vit_pkg::*;

  //--------------------------------------------------------------------------
  // declarations
  //--------------------------------------------------------------------------

  logic           accept;
  trb_cmd_t       sel_cmd;

  logic           busy;
  logic           first;
  logic           last;
  trb_ram_addr_t  cnt;
  trb_ram_addr_t  skip_cnt;

  stateb_t        cmd_state;
  tag_t           cmd_tag;

  // read pipeline flags, bit 1 lines up with irword, bit 2 with word_q
  logic [2:0]     rd_val;
  logic [2:0]     rd_sop;
  logic [2:0]     rd_eop;
  logic [2:0]     rd_mask;

  // per-block end state and tag travel with the sop flag
  stateb_t        st_pipe  [3];
  tag_t           tag_pipe [3];

  trb_word_t      word_q;

  stateb_t        state;
  stateb_t        cur_state;
  stateb_t        pre_state;
  tag_t           blk_tag;
  tag_t           cur_tag;
  logic           data_bit;
  boutputs_t      cdata;

  trb_lifo_addr_t next_waddr;
  trb_lifo_addr_t base_waddr;
  logic           wr_now;
  logic           end_q;

  //--------------------------------------------------------------------------
  // command accept and read sweep
  //--------------------------------------------------------------------------

  // ready again in the last read cycle
  assign last    = busy & (cnt == '0);
  assign ordy    = !busy | (cnt == '0);
  assign accept  = ordy & (istart | iflush);
  // start wins over flush
  assign sel_cmd = istart ? icmd : ifcmd;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy  <= 1'b0;
      first <= 1'b0;
    end else if (iclkena) begin
      first <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (last) begin
        busy <= 1'b0;
      end
    end
  end

  // sweep counters and command payload
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (accept) begin
        oraddr    <= sel_cmd.raddr;
        cnt       <= sel_cmd.size_m1;
        skip_cnt  <= sel_cmd.skip;
        cmd_state <= sel_cmd.state;
        cmd_tag   <= sel_cmd.tag;
      end else if (busy) begin
        oraddr <= oraddr - 1'b1;
        cnt    <= cnt - 1'b1;
        // newest steps masked until skip runs out
        if (skip_cnt != '0) begin
          skip_cnt <= skip_cnt - 1'b1;
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // align control with memory data
  // two cycles ram latency plus one reclock
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_val <= '0;
      rd_sop <= '0;
      rd_eop <= '0;
    end else if (iclkena) begin
      rd_val <= {rd_val[1:0], busy};
      rd_sop <= {rd_sop[1:0], first};
      rd_eop <= {rd_eop[1:0], last};
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      rd_mask     <= {rd_mask[1:0], (skip_cnt != '0)};
      st_pipe[0]  <= cmd_state;
      st_pipe[1]  <= st_pipe[0];
      st_pipe[2]  <= st_pipe[1];
      tag_pipe[0] <= cmd_tag;
      tag_pipe[1] <= tag_pipe[0];
      tag_pipe[2] <= tag_pipe[1];
      word_q      <= irword;
    end
  end

  //--------------------------------------------------------------------------
  // traceback step
  //--------------------------------------------------------------------------

  // first step of a block starts from the command end state
  assign cur_state = rd_sop[2] ? st_pipe[2]  : state;
  assign cur_tag   = rd_sop[2] ? tag_pipe[2] : blk_tag;

  // survivor decision of the current state picks the predecessor
  assign pre_state = get_pre_state(cur_state, word_q.decision[cur_state]);
  assign data_bit  = get_binput(cur_state);
  // re-encode the transition pre_state -> cur_state
  assign cdata     = get_outputs(pre_state, data_bit);

  assign wr_now     = rd_val[2] & !rd_mask[2];
  assign base_waddr = rd_sop[2] ? '0 : next_waddr;

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (rd_val[2]) begin
        state      <= pre_state;
        blk_tag    <= cur_tag;
        next_waddr <= base_waddr + wr_now;
      end
      // obit holds the last written bit between writes
      if (wr_now) begin
        obit.dat    <= data_bit;
        obit.biterr <= word_q.hd ^ cdata;
        obit.waddr  <= base_waddr;
        obit.tag    <= cur_tag;
      end
    end
  end

  // flush one cycle after the last step result
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite <= 1'b0;
      end_q  <= 1'b0;
      oflush <= 1'b0;
    end else if (iclkena) begin
      owrite <= wr_now;
      end_q  <= rd_val[2] & rd_eop[2];
      oflush <= end_q;
    end
  end

endmodule

// File: source/vit_trb_lifo.sv
// two-bank reversal buffer, engine writes newest-first and the output reads oldest-first
`timescale 1ns/1ps

module vit_trb_lifo (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  // engine side
  input  logic               iwrite,
  input  vit_pkg::trb_bit_t  ibit,
  input  logic               iflush,
  // output stream
  output logic               oval,
  output logic               osop,
  output logic               oeop,
  output logic               odat,
  output vit_pkg::boutputs_t obiterr,
  output vit_pkg::tag_t      otag
);

  import vit_pkg::*;

  //--------------------------------------------------------------------------
  // declarations
  //--------------------------------------------------------------------------

  logic           dat_mem [2][cLIFO_DEPTH];
  boutputs_t      err_mem [2][cLIFO_DEPTH];

  logic           wbank;
  logic           wsel;
  logic           rbank;

  // last write of the block being filled
  logic           wr_any;
  trb_lifo_addr_t wr_last;
  tag_t           wr_tag;

  logic           rd_start;
  logic           rd_active;
  logic           rd_first;
  trb_lifo_addr_t rd_addr;
  tag_t           rd_tag;

  //--------------------------------------------------------------------------
  // write side
  //--------------------------------------------------------------------------

  // a write in the flush cycle already belongs to the next block
  assign wsel     = wbank ^ iflush;
  assign rd_start = iflush & wr_any;

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (iwrite) begin
        dat_mem[wsel][ibit.waddr] <= ibit.dat;
        err_mem[wsel][ibit.waddr] <= ibit.biterr;
        wr_last                   <= ibit.waddr;
        wr_tag                    <= ibit.tag;
      end
      // length and tag of the finished block
      if (rd_start) begin
        rd_tag <= wr_tag;
        rbank  <= wbank;
      end
    end
  end

  //--------------------------------------------------------------------------
  // bank swap and descending readout
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wbank     <= 1'b0;
      wr_any    <= 1'b0;
      rd_active <= 1'b0;
      rd_first  <= 1'b0;
      rd_addr   <= '0;
    end else if (iclkena) begin
      if (iflush) begin
        wbank  <= ~wbank;
        wr_any <= iwrite;
      end else if (iwrite) begin
        wr_any <= 1'b1;
      end
      rd_first <= rd_start;
      if (rd_start) begin
        rd_active <= 1'b1;
        rd_addr   <= wr_last;
      end else if (rd_active) begin
        rd_addr <= rd_addr - 1'b1;
        // address 0 holds the newest kept bit
        if (rd_addr == '0) begin
          rd_active <= 1'b0;
        end
      end
    end
  end

  // highest address is the oldest bit
  assign oval    = rd_active;
  assign osop    = rd_active & rd_first;
  assign oeop    = rd_active & (rd_addr == '0);
  assign odat    = dat_mem[rbank][rd_addr];
  assign obiterr = err_mem[rbank][rd_addr];
  assign otag    = rd_tag;

endmodule

// File: source/vit_trb_ram.sv
// survivor word memory between the ACS stage and the traceback engine, two-cycle read
`timescale 1ns/1ps

module vit_trb_ram (
  input  logic                   iclk,
  input  logic                   iclkena,
  // write side, ACS
  input  logic                   iwrite,
  input  vit_pkg::trb_ram_addr_t iwaddr,
  input  vit_pkg::trb_word_t     iwword,
  // read side, traceback engine
  input  vit_pkg::trb_ram_addr_t iraddr,
  output vit_pkg::trb_word_t     orword
);

  import vit_pkg::*;

  //--------------------------------------------------------------------------
  // storage
  //--------------------------------------------------------------------------

  trb_word_t     mem [cRAM_DEPTH];

  // read address register, first read stage
  trb_ram_addr_t raddr_q;

  // write port
  // word stored on every enabled edge while iwrite is high
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (iwrite) begin
        mem[iwaddr] <= iwword;
      end
    end
  end

  //--------------------------------------------------------------------------
  // read port
  //--------------------------------------------------------------------------

  // address reg then data reg
  // engine counts on exactly two enabled cycles
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      raddr_q <= iraddr;
      orword  <= mem[raddr_q];
    end
  end

endmodule

// File: source/vit_trb_top.sv
// traceback top level, joins survivor memory, traceback engine and reversal buffer
`timescale 1ns/1ps

module vit_trb_top (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  // survivor write from ACS
  input  logic                   iwrite,
  input  vit_pkg::trb_ram_addr_t iwaddr,
  input  vit_pkg::trb_word_t     iwword,
  // traceback commands
  input  logic                   istart,
  input  vit_pkg::trb_cmd_t      icmd,
  input  logic                   iflush,
  input  vit_pkg::trb_cmd_t      ifcmd,
  output logic                   ordy,
  // decoded stream, forward order
  output logic                   oval,
  output logic                   osop,
  output logic                   oeop,
  output logic                   odat,
  output vit_pkg::boutputs_t     obiterr,
  output vit_pkg::tag_t          otag
);

  import vit_pkg::*;

  //--------------------------------------------------------------------------
  // internal wires
  //--------------------------------------------------------------------------

  trb_ram_addr_t raddr;
  trb_word_t     rword;

  logic          bit_write;
  logic          bit_flush;
  trb_bit_t      bit_data;

  // survivor memory
  vit_trb_ram ram_inst (
    .iclk    (iclk),
    .iclkena (iclkena),
    .iwrite  (iwrite),
    .iwaddr  (iwaddr),
    .iwword  (iwword),
    .iraddr  (raddr),
    .orword  (rword)
  );

  // traceback engine
  vit_trb_engine engine_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .istart  (istart),
    .icmd    (icmd),
    .iflush  (iflush),
    .ifcmd   (ifcmd),
    .ordy    (ordy),
    .oraddr  (raddr),
    .irword  (rword),
    .owrite  (bit_write),
    .oflush  (bit_flush),
    .obit    (bit_data)
  );

  // reversal buffer, newest-first in, oldest-first out
  vit_trb_lifo lifo_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .iwrite  (bit_write),
    .ibit    (bit_data),
    .iflush  (bit_flush),
    .oval    (oval),
    .osop    (osop),
    .oeop    (oeop),
    .odat    (odat),
    .obiterr (obiterr),
    .otag    (otag)
  );

endmodule

// File: verification/vit_trb_tb.sv
// testbench for the traceback top level, run from the file list with vit_trb_tb as top
`timescale 1ns/1ps

module vit_trb_tb;

  import vit_pkg::*;

  //--------------------------------------------------------------------------
  // run length
  //--------------------------------------------------------------------------

  // steps over all blocks, each one written, read back and streamed out
  localparam int cSTEP_SUM    = 48 + 48 + 40 + 20 + 24 + 24;
  localparam int cBLOCKS      = 6;
  localparam int cCYCLE_LIMIT = 3 * cSTEP_SUM + 40 * cBLOCKS + 100;

  // one expected output beat
  typedef struct packed {
    logic      dat;
    boutputs_t err;
    tag_t      tag;
    logic      sop;
    logic      eop;
  } beat_t;

  logic          iclk;
  logic          ireset;
  logic          iclkena;
  logic          iwrite;
  trb_ram_addr_t iwaddr;
  trb_word_t     iwword;
  logic          istart;
  trb_cmd_t      icmd;
  logic          iflush;
  trb_cmd_t      ifcmd;
  logic          ordy;
  logic          oval;
  logic          osop;
  logic          oeop;
  logic          odat;
  boutputs_t     obiterr;
  tag_t          otag;

  // reference queue, oldest bit of the oldest block at the front
  beat_t         exp_q [$];
  beat_t         exp_head;
  logic          exp_have;
  logic          cmd_seen;

  int            errors;
  int            tests_run;
  int            tests_failed;
  int            beats;
  int            cycles;
  logic [31:0]   rng_state;

  vit_trb_top vit_trb_top_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .iwrite  (iwrite),
    .iwaddr  (iwaddr),
    .iwword  (iwword),
    .istart  (istart),
    .icmd    (icmd),
    .iflush  (iflush),
    .ifcmd   (ifcmd),
    .ordy    (ordy),
    .oval    (oval),
    .osop    (osop),
    .oeop    (oeop),
    .odat    (odat),
    .obiterr (obiterr),
    .otag    (otag)
  );

  // 20 ns period
  always #10 iclk = ~iclk;

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------

  // lcg, upper bits are the better ones
  function automatic logic [15:0] rand_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expv);
    errors = errors + 1;
    $display("FAIL %0t %s got %0h expected %0h", $time, name, got, expv);
  endtask

  task automatic report_error(input string what);
    errors = errors + 1;
    $display("error at %0t: %s", $time, what);
  endtask

  // encode a random block, store its survivor words, queue the kept bits
  task automatic load_block(input int base, input int len, input int skip,
                            input int flip_step, input tag_t tag,
                            output trb_cmd_t cmd);
    int        t;
    logic [15:0] r;
    logic      b;
    logic      s1;
    logic      s0;
    boutputs_t clean;
    boutputs_t flip;
    trb_word_t word;
    logic      info_a [64];
    boutputs_t flip_a [64];
    beat_t     beat;
    s1 = 1'b0;
    s0 = 1'b0;
    for (t = 0; t < len; t++) begin
      r = rand_next();
      b = r[9];
      // generators 7 and 5 over newest bit, s1, s0
      clean = {b ^ s1 ^ s0, b ^ s0};
      flip  = 2'b00;
      if (flip_step != 0 && (t % flip_step) == 1) begin
        flip = r[3:2];
        if (flip == 2'b00) begin
          flip = 2'b11;
        end
      end
      // off-path decisions random
      word.decision = r[15:12];
      // true path, state {b, s1} came from {s1, s0}
      word.decision[{b, s1}] = s0;
      word.hd = clean ^ flip;
      @(negedge iclk);
      iwrite = 1'b1;
      iwaddr = trb_ram_addr_t'(base + t);
      iwword = word;
      info_a[t] = b;
      flip_a[t] = flip;
      s0 = s1;
      s1 = b;
    end
    @(negedge iclk);
    iwrite = 1'b0;
    cmd.raddr   = trb_ram_addr_t'(base + len - 1);
    cmd.size_m1 = trb_ram_addr_t'(len - 1);
    cmd.skip    = trb_ram_addr_t'(skip);
    cmd.state   = {s1, s0};
    cmd.tag     = tag;
    // newest skip steps never come out
    for (t = 0; t < len - skip; t++) begin
      beat.dat = info_a[t];
      beat.err = flip_a[t];
      beat.tag = tag;
      beat.sop = (t == 0);
      beat.eop = (t == len - skip - 1);
      exp_q.push_back(beat);
    end
  endtask

  // one-cycle request at the first falling edge with ordy high
  task automatic issue_cmd(input logic use_start, input logic use_flush,
                           input trb_cmd_t scmd, input trb_cmd_t fcmd);
    @(negedge iclk);
    while (!ordy) begin
      @(negedge iclk);
    end
    istart   = use_start;
    iflush   = use_flush;
    icmd     = scmd;
    ifcmd    = fcmd;
    cmd_seen = 1'b1;
    @(negedge iclk);
    istart = 1'b0;
    iflush = 1'b0;
  endtask

  task automatic wait_drain();
    @(negedge iclk);
    while (exp_q.size() != 0) begin
      @(negedge iclk);
    end
    repeat (4) @(negedge iclk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run = tests_run + 1;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  //--------------------------------------------------------------------------
  // output monitor and checks
  //--------------------------------------------------------------------------

  // mid-cycle, take the expected beat for the current output
  always @(negedge iclk) begin
    if (oval) begin
      beats = beats + 1;
      if (exp_q.size() > 0) begin
        exp_head = exp_q.pop_front();
        exp_have = 1'b1;
      end else begin
        exp_have = 1'b0;
      end
    end
  end

  a_idle: assert property (@(posedge iclk) disable iff (ireset) !cmd_seen |-> !oval)
    else report_error("output valid before any command");
  a_extra: assert property (@(posedge iclk) disable iff (ireset) oval |-> exp_have)
    else report_error("output beat with no expected bit pending");
  a_dat: assert property (@(posedge iclk) disable iff (ireset)
                          oval && exp_have |-> odat == exp_head.dat)
    else report_mismatch("odat", $sampled(odat), exp_head.dat);
  a_err: assert property (@(posedge iclk) disable iff (ireset)
                          oval && exp_have |-> obiterr == exp_head.err)
    else report_mismatch("obiterr", $sampled(obiterr), exp_head.err);
  a_tag: assert property (@(posedge iclk) disable iff (ireset)
                          oval && exp_have |-> otag == exp_head.tag)
    else report_mismatch("otag", $sampled(otag), exp_head.tag);
  a_sop: assert property (@(posedge iclk) disable iff (ireset)
                          oval && exp_have |-> osop == exp_head.sop)
    else report_mismatch("osop", $sampled(osop), exp_head.sop);
  a_eop: assert property (@(posedge iclk) disable iff (ireset)
                          oval && exp_have |-> oeop == exp_head.eop)
    else report_mismatch("oeop", $sampled(oeop), exp_head.eop);

  // run limit
  always @(posedge iclk) begin
    cycles = cycles + 1;
    if (cycles >= cCYCLE_LIMIT) begin
      $display("timeout: run exceeded %0d cycles, %0d bits still expected",
               cCYCLE_LIMIT, exp_q.size());
      $display("Testbench failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------

  initial begin : stimulus
    int       err0;
    trb_cmd_t cmd_a;
    trb_cmd_t cmd_b;
    trb_cmd_t junk;
    rng_state    = 32'd36;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    beats        = 0;
    cycles       = 0;
    exp_have     = 1'b0;
    exp_head     = '0;
    cmd_seen     = 1'b0;
    iclk         = 1'b0;
    ireset       = 1'b1;
    iclkena      = 1'b1;
    iwrite       = 1'b0;
    iwaddr       = '0;
    iwword       = '0;
    istart       = 1'b0;
    icmd         = '0;
    iflush       = 1'b0;
    ifcmd        = '0;
    repeat (10) @(negedge iclk);
    ireset = 1'b0;

    // quiet output before any command
    err0 = errors;
    @(negedge iclk);
    assert (ordy) else report_error("ordy low after reset");
    repeat (20) @(negedge iclk);
    finish_test("idle after reset", err0);

    // clean 48-step block
    err0 = errors;
    load_block(0, 48, 0, 0, 4'd1, cmd_a);
    issue_cmd(1'b1, 1'b0, cmd_a, '0);
    wait_drain();
    finish_test("full traceback", err0);

    // flipped received pairs
    err0 = errors;
    load_block(8, 48, 0, 3, 4'd2, cmd_a);
    issue_cmd(1'b1, 1'b0, cmd_a, '0);
    wait_drain();
    finish_test("error flags", err0);

    // 8 newest steps dropped
    err0 = errors;
    load_block(20, 40, 8, 7, 4'd3, cmd_a);
    issue_cmd(1'b1, 1'b0, cmd_a, '0);
    wait_drain();
    finish_test("skip newest steps", err0);

    // flush only, start side holds another tag
    err0 = errors;
    load_block(40, 20, 0, 4, 4'd5, cmd_a);
    cmd_b       = cmd_a;
    cmd_b.tag   = 4'd9;
    cmd_b.raddr = 6'd3;
    issue_cmd(1'b0, 1'b1, cmd_b, cmd_a);
    wait_drain();
    finish_test("flush command", err0);

    // two blocks back to back
    err0 = errors;
    load_block(0, 24, 0, 5, 4'd6, cmd_a);
    load_block(32, 24, 2, 6, 4'd7, cmd_b);
    junk     = cmd_b;
    junk.tag = 4'd15;
    issue_cmd(1'b1, 1'b0, cmd_a, '0);
    // both requests while busy, ignored
    assert (!ordy) else report_error("ordy high right after accept");
    istart = 1'b1;
    iflush = 1'b1;
    icmd   = junk;
    ifcmd  = junk;
    @(negedge iclk);
    istart = 1'b0;
    iflush = 1'b0;
    issue_cmd(1'b1, 1'b0, cmd_b, '0);
    assert (!ordy) else report_error("start in the ordy return cycle not accepted");
    wait_drain();
    finish_test("back-to-back", err0);

    repeat (10) @(negedge iclk);
    $display("tests %0d, failed %0d, errors %0d, output beats %0d",
             tests_run, tests_failed, errors, beats);
    if (errors == 0 && tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: vit_trb_top.f
source/vit_pkg.sv
source/vit_trb_ram.sv
source/vit_trb_engine.sv
source/vit_trb_lifo.sv
source/vit_trb_top.sv
verification/vit_trb_tb.sv
